//--- design/malu_datapath.sv
`timescale 1ns/10ps

module malu_datapath (
    input  logic                       clock,
    input  logic                       i_rst,
    input  logic                       i_valid,
    input  logic                       i_flush,
    input  malu_pkg::malu_op_t         i_op,
    input  logic [malu_pkg::XLEN-1:0]  i_rs2,
    output logic [malu_pkg::CNT_W-1:0] o_counter,
    output logic [malu_pkg::CNT_W-1:0] o_next_counter,
    output logic [malu_pkg::ACC_W-1:0] o_accumulator,
    output logic [malu_pkg::XLEN-1:0]  o_argument,
    input  logic [malu_pkg::XLEN-1:0]  i_mul_add_lhs,
    input  logic [malu_pkg::XLEN-1:0]  i_mul_add_rhs,
    input  logic                       i_mul_add_sub,
    input  logic [malu_pkg::XLEN-1:0]  i_div_add_lhs,
    input  logic [malu_pkg::XLEN-1:0]  i_div_add_rhs,
    input  logic                       i_div_add_sub,
    output logic [malu_pkg::XLEN-1:0]  o_add_sum,
    output logic                       o_add_carry,
    input  logic [malu_pkg::ACC_W-1:0] i_mul_next_acc,
    input  logic [malu_pkg::XLEN-1:0]  i_mul_next_arg,
    input  logic                       i_mul_finished,
    input  logic [malu_pkg::ACC_W-1:0] i_div_next_acc,
    input  logic [malu_pkg::XLEN-1:0]  i_div_next_arg,
    input  logic                       i_div_finished,
    input  logic [malu_pkg::XLEN-1:0]  i_div_result,
    output logic                       o_ready,
    output logic [malu_pkg::XLEN-1:0]  o_result_hi,
    output logic [malu_pkg::XLEN-1:0]  o_result_lo
);

    import malu_pkg::*;

    logic             count_en;                        // Set once operands are loaded
    logic             op_div;                          // Divide or remainder selected
    logic [XLEN-1:0]  add_lhs;
    logic [XLEN-1:0]  add_rhs;
    logic             add_sub;
    logic [XLEN:0]    add_full;                        // Sum plus carry out
    logic [ACC_W-1:0] next_acc;
    logic [XLEN-1:0]  next_arg;
    logic             finished;

    assign op_div = (i_op == OP_DIV) || (i_op == OP_REM);

    // ------------------------------
    // Step unit select
    // ------------------------------

    always_comb begin
        case (i_op)
            OP_MUL: begin
                add_lhs  = i_mul_add_lhs;
                add_rhs  = i_mul_add_rhs;
                add_sub  = i_mul_add_sub;
                next_acc = i_mul_next_acc;
                next_arg = i_mul_next_arg;
                finished = i_mul_finished;
            end
            OP_DIV, OP_REM: begin
                add_lhs  = i_div_add_lhs;
                add_rhs  = i_div_add_rhs;
                add_sub  = i_div_add_sub;
                next_acc = i_div_next_acc;
                next_arg = i_div_next_arg;
                finished = i_div_finished;
            end
            default: begin
                add_lhs  = '0;
                add_rhs  = '0;
                add_sub  = 1'b0;
                next_acc = '0;
                next_arg = '0;
                finished = 1'b0;
            end
        endcase
    end

    // Shared add/subtract, subtract as lhs + ~rhs + 1
    assign add_full    = {1'b0, add_lhs} + {1'b0, add_rhs ^ {XLEN{add_sub}}}
                       + {{XLEN{1'b0}}, add_sub};
    assign o_add_sum   = add_full[XLEN-1:0];
    assign o_add_carry = add_full[XLEN];

    // ------------------------------
    // State registers
    // ------------------------------

    always_ff @(posedge clock) begin
        if (i_rst || i_flush || !i_valid) begin
            count_en <= 1'b0;
        end else if (!count_en) begin
            count_en <= 1'b1;                          // Load edge
        end
    end

    always_ff @(posedge clock) begin
        if (i_rst || i_flush || !i_valid) begin
            o_counter     <= '0;
            o_accumulator <= '0;
            o_argument    <= '0;
        end else if (!count_en) begin
            o_counter     <= '0;
            o_accumulator <= op_div ? next_acc : '0;   // Divider supplies shifted divisor
            o_argument    <= op_div ? next_arg : i_rs2; // Multiplier bits or |dividend|
        end else if (!finished) begin
            o_counter     <= o_next_counter;
            o_accumulator <= next_acc;
            o_argument    <= next_arg;
        end
    end

    assign o_next_counter = o_counter + CNT_W'(1);

    // ------------------------------
    // Handshake and result
    // ------------------------------

    assign o_ready     = finished;
    assign o_result_hi = op_div ? '0 : o_accumulator[ACC_W-1:XLEN];
    assign o_result_lo = op_div ? i_div_result : o_accumulator[XLEN-1:0];

endmodule

//--- design/malu_divrem_step.sv
`timescale 1ns/10ps

module malu_divrem_step (
    input  logic                       clock,
    input  logic                       i_rst,
    input  logic                       i_valid,
    input  logic                       i_flush,
    input  malu_pkg::malu_op_t         i_op,
    input  logic                       i_div_unsigned,
    input  logic [malu_pkg::XLEN-1:0]  i_rs1,            // Dividend
    input  logic [malu_pkg::XLEN-1:0]  i_rs2,            // Divisor
    input  logic [malu_pkg::CNT_W-1:0] i_counter,
    input  logic [malu_pkg::ACC_W-1:0] i_accumulator,    // Shifted divisor
    input  logic [malu_pkg::XLEN-1:0]  i_argument,       // Partial remainder
    input  logic [malu_pkg::XLEN-1:0]  i_add_sum,
    output logic [malu_pkg::XLEN-1:0]  o_add_lhs,
    output logic [malu_pkg::XLEN-1:0]  o_add_rhs,
    output logic                       o_add_sub,
    output logic [malu_pkg::ACC_W-1:0] o_next_acc,
    output logic [malu_pkg::XLEN-1:0]  o_next_arg,
    output logic                       o_finished,
    output logic [malu_pkg::XLEN-1:0]  o_result
);

    import malu_pkg::*;

    logic             is_divrem;
    logic             signed_op;
    logic             signed_lhs;                      // Negative signed dividend
    logic             signed_rhs;                      // Negative signed divisor
    logic             div_run;
    logic             div_done;
    logic             div_start;
    logic             last_step;
    logic             div_less;                        // Divisor fits in remainder
    logic             outsign;                         // Negate result at the end
    logic [XLEN-1:0]  quotient;
    logic [XLEN-1:0]  qmask;
    logic [XLEN-1:0]  divisor_mag;
    logic [XLEN-1:0]  dividend_mag;
    logic [ACC_W-1:0] divisor_start;
    logic [XLEN-1:0]  remainder_out;
    logic [XLEN-1:0]  quotient_out;

    // ------------------------------
    // Operation decode
    // ------------------------------

    assign is_divrem  = i_valid && ((i_op == OP_DIV) || (i_op == OP_REM));
    assign signed_op  = is_divrem && !i_div_unsigned;
    assign signed_lhs = signed_op && i_rs1[XLEN-1];
    assign signed_rhs = signed_op && i_rs2[XLEN-1];

    assign div_start  = is_divrem && !div_run && !div_done;
    assign last_step  = div_run && (i_counter == CNT_W'(DIV_LAST_STEP));

    // Magnitudes, 32'h80000000 stays correct read as unsigned
    assign divisor_mag   = signed_rhs ? -i_rs2 : i_rs2;
    assign dividend_mag  = signed_lhs ? -i_rs1 : i_rs1;
    assign divisor_start = {1'b0, divisor_mag, {(XLEN-1){1'b0}}};

    // ------------------------------
    // Restoring step
    // ------------------------------

    assign div_less  = i_accumulator <= {{(ACC_W-XLEN){1'b0}}, i_argument};
    assign qmask     = {1'b1, {(XLEN-1){1'b0}}} >> i_counter; // Quotient bit for this step

    assign o_add_lhs = i_argument;
    assign o_add_rhs = i_accumulator[XLEN-1:0];
    assign o_add_sub = 1'b1;                           // Always remainder - divisor

    always_comb begin
        if (div_start) begin
            o_next_acc = divisor_start;
        end else if (!last_step && !div_done) begin
            o_next_acc = i_accumulator >> 1;
        end else begin
            o_next_acc = i_accumulator;
        end
    end

    always_comb begin
        if (div_start) begin
            o_next_arg = dividend_mag;
        end else if (div_less) begin
            o_next_arg = i_add_sum;                    // Keep the reduced remainder
        end else begin
            o_next_arg = i_argument;
        end
    end

    // ------------------------------
    // Run / done sequence
    // ------------------------------

    always_ff @(posedge clock) begin
        if (i_rst || i_flush || !i_valid) begin
            div_run  <= 1'b0;
            div_done <= 1'b0;
        end else if (div_start) begin
            div_run  <= 1'b1;
        end else if (last_step) begin
            div_run  <= 1'b0;
            div_done <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (div_start) begin
            quotient <= '0;
            // Divide by zero keeps the all-ones quotient unsigned
            outsign  <= ((i_op == OP_DIV) && signed_op && (i_rs1[XLEN-1] != i_rs2[XLEN-1])
                         && (|i_rs2))
                     || ((i_op == OP_REM) && signed_lhs);
        end else if (div_run && div_less) begin
            quotient <= quotient | qmask;
        end
    end

    assign o_finished = div_done;

    // ------------------------------
    // Sign fix-up and result
    // ------------------------------

    assign remainder_out = outsign ? -i_argument : i_argument; // Takes dividend sign
    assign quotient_out  = outsign ? -quotient : quotient;
    assign o_result      = (i_op == OP_REM) ? remainder_out : quotient_out;

endmodule

//--- design/malu_mul_step.sv
`timescale 1ns/10ps

module malu_mul_step (
    input  logic [malu_pkg::XLEN-1:0]  i_rs1,
    input  logic [malu_pkg::XLEN-1:0]  i_rs2,
    input  logic [malu_pkg::CNT_W-1:0] i_counter,
    input  logic [malu_pkg::CNT_W-1:0] i_next_counter,
    input  logic [malu_pkg::ACC_W-1:0] i_accumulator,
    input  logic [malu_pkg::XLEN-1:0]  i_argument,       // Remaining multiplier bits
    input  logic                       i_lhs_sign,
    input  logic                       i_rhs_sign,
    input  logic [malu_pkg::XLEN-1:0]  i_add_sum,
    input  logic                       i_add_carry,
    output logic [malu_pkg::XLEN-1:0]  o_add_lhs,
    output logic [malu_pkg::XLEN-1:0]  o_add_rhs,
    output logic                       o_add_sub,
    output logic [malu_pkg::ACC_W-1:0] o_next_acc,
    output logic [malu_pkg::XLEN-1:0]  o_next_arg,
    output logic                       o_finished
);

    import malu_pkg::*;

    logic          add_en;                             // Current multiplier bit
    logic          sub_last;                           // Negative weight of signed rs2 MSB
    logic          lhs_ext;                            // Bit 32 of the partial product
    logic          rhs_ext;                            // Bit 32 of the addend
    logic          sum_top;
    logic [XLEN:0] step_sum;

    assign add_en   = i_argument[0];

    // For signed rs2 the MSB carries weight -2^31, so the last step subtracts
    assign sub_last = i_rhs_sign && i_rs2[XLEN-1] && (i_next_counter == CNT_W'(MUL_STEPS));

    assign lhs_ext  = i_lhs_sign && i_accumulator[ACC_W-1];
    assign rhs_ext  = add_en && i_lhs_sign && i_rs1[XLEN-1];

    // ------------------------------
    // Adder operands
    // ------------------------------

    assign o_add_lhs = i_accumulator[ACC_W-1:XLEN];
    assign o_add_rhs = add_en ? i_rs1 : '0;
    assign o_add_sub = sub_last;

    // Extend the 32-bit adder to 33 bits with a one-bit full add
    assign sum_top  = lhs_ext ^ rhs_ext ^ sub_last ^ i_add_carry;
    assign step_sum = {sum_top, i_add_sum};

    // ------------------------------
    // Next state
    // ------------------------------

    assign o_next_acc = {step_sum, i_accumulator[XLEN-1:1]}; // Shift right with new top
    assign o_next_arg = {1'b0, i_argument[XLEN-1:1]};
    assign o_finished = (i_counter == CNT_W'(MUL_STEPS));

endmodule

//--- design/malu_pkg.sv
package malu_pkg;

    // ------------------------------
    // Word and accumulator widths
    // ------------------------------

    localparam int unsigned XLEN  = 32;            // Operand and result width
    localparam int unsigned ACC_W = 64;            // Double-width accumulator

    // ------------------------------
    // Step counter
    // ------------------------------

    localparam int unsigned CNT_W = 6;             // Wide enough to reach MUL_STEPS

    // Multiply ends once the counter has seen one step per rs2 bit
    localparam int unsigned MUL_STEPS = 32;

    // Division checks this value while running to flag its final step
    localparam int unsigned DIV_LAST_STEP = 31;

    // ------------------------------
    // Operation select
    // ------------------------------

    typedef enum logic [1:0] {
        OP_NONE = 2'd0,                            // Idle, no unit selected
        OP_MUL  = 2'd1,                            // MUL / MULH / MULHU / MULHSU
        OP_DIV  = 2'd2,                            // DIV / DIVU
        OP_REM  = 2'd3                             // REM / REMU
    } malu_op_t;

endpackage

//--- design/malu_top.sv
`timescale 1ns/10ps

module malu_top (
    input  logic                     clock,
    input  logic                     i_rst,
    input  logic                     i_valid,          // Operands valid, held until ready
    input  logic                     i_flush,          // Abort current operation
    input  malu_pkg::malu_op_t       i_op,
    input  logic [malu_pkg::XLEN-1:0] i_rs1,
    input  logic [malu_pkg::XLEN-1:0] i_rs2,
    input  logic                     i_lhs_sign,       // rs1 signed for multiply
    input  logic                     i_rhs_sign,       // rs2 signed for multiply
    input  logic                     i_div_unsigned,   // DIVU / REMU
    output logic                     o_ready,
    output logic [malu_pkg::XLEN-1:0] o_result_hi,
    output logic [malu_pkg::XLEN-1:0] o_result_lo
);

    import malu_pkg::*;

    // ------------------------------
    // Shared state and adder
    // ------------------------------

    logic [CNT_W-1:0] counter;
    logic [CNT_W-1:0] next_counter;
    logic [ACC_W-1:0] accumulator;
    logic [XLEN-1:0]  argument;
    logic [XLEN-1:0]  add_sum;
    logic             add_carry;                       // Carry out of bit 31

    // ------------------------------
    // Step unit returns
    // ------------------------------

    logic [XLEN-1:0]  mul_add_lhs;
    logic [XLEN-1:0]  mul_add_rhs;
    logic             mul_add_sub;
    logic [ACC_W-1:0] mul_next_acc;
    logic [XLEN-1:0]  mul_next_arg;
    logic             mul_finished;

    logic [XLEN-1:0]  div_add_lhs;
    logic [XLEN-1:0]  div_add_rhs;
    logic             div_add_sub;
    logic [ACC_W-1:0] div_next_acc;
    logic [XLEN-1:0]  div_next_arg;
    logic             div_finished;
    logic [XLEN-1:0]  div_result;

    malu_datapath u_malu_datapath (
        .clock          (clock),
        .i_rst          (i_rst),
        .i_valid        (i_valid),
        .i_flush        (i_flush),
        .i_op           (i_op),
        .i_rs2          (i_rs2),
        .o_counter      (counter),
        .o_next_counter (next_counter),
        .o_accumulator  (accumulator),
        .o_argument     (argument),
        .i_mul_add_lhs  (mul_add_lhs),
        .i_mul_add_rhs  (mul_add_rhs),
        .i_mul_add_sub  (mul_add_sub),
        .i_div_add_lhs  (div_add_lhs),
        .i_div_add_rhs  (div_add_rhs),
        .i_div_add_sub  (div_add_sub),
        .o_add_sum      (add_sum),
        .o_add_carry    (add_carry),
        .i_mul_next_acc (mul_next_acc),
        .i_mul_next_arg (mul_next_arg),
        .i_mul_finished (mul_finished),
        .i_div_next_acc (div_next_acc),
        .i_div_next_arg (div_next_arg),
        .i_div_finished (div_finished),
        .i_div_result   (div_result),
        .o_ready        (o_ready),
        .o_result_hi    (o_result_hi),
        .o_result_lo    (o_result_lo)
    );

    malu_mul_step u_malu_mul_step (
        .i_rs1          (i_rs1),
        .i_rs2          (i_rs2),
        .i_counter      (counter),
        .i_next_counter (next_counter),
        .i_accumulator  (accumulator),
        .i_argument     (argument),
        .i_lhs_sign     (i_lhs_sign),
        .i_rhs_sign     (i_rhs_sign),
        .i_add_sum      (add_sum),
        .i_add_carry    (add_carry),
        .o_add_lhs      (mul_add_lhs),
        .o_add_rhs      (mul_add_rhs),
        .o_add_sub      (mul_add_sub),
        .o_next_acc     (mul_next_acc),
        .o_next_arg     (mul_next_arg),
        .o_finished     (mul_finished)
    );

    malu_divrem_step u_malu_divrem_step (
        .clock          (clock),
        .i_rst          (i_rst),
        .i_valid        (i_valid),
        .i_flush        (i_flush),
        .i_op           (i_op),
        .i_div_unsigned (i_div_unsigned),
        .i_rs1          (i_rs1),
        .i_rs2          (i_rs2),
        .i_counter      (counter),
        .i_accumulator  (accumulator),
        .i_argument     (argument),
        .i_add_sum      (add_sum),
        .o_add_lhs      (div_add_lhs),
        .o_add_rhs      (div_add_rhs),
        .o_add_sub      (div_add_sub),
        .o_next_acc     (div_next_acc),
        .o_next_arg     (div_next_arg),
        .o_finished     (div_finished),
        .o_result       (div_result)
    );

endmodule

//--- sim.f
design/malu_pkg.sv
design/malu_mul_step.sv
design/malu_divrem_step.sv
design/malu_datapath.sv
design/malu_top.sv
sim/malu_properties.sv
sim/malu_tb.sv

//--- sim/malu_properties.sv
`timescale 1ns/10ps

module malu_properties (
    input logic                      clock,
    input logic                      i_rst,
    input logic                      i_valid,
    input logic                      i_ready,
    input logic [malu_pkg::XLEN-1:0] i_result_hi,
    input logic [malu_pkg::XLEN-1:0] i_result_lo
);

    int unsigned fail_count = 0;                       // Failed assertions so far

    // State clears on the reset edge
    a_ready_after_reset: assert property (@(posedge clock) i_rst |=> !i_ready)
        else begin
            fail_count++;
            $error("o_ready high in the cycle after reset");
        end

    // Dropping valid returns the unit to idle
    a_ready_needs_valid: assert property (@(posedge clock) disable iff (i_rst)
        !i_valid |=> !i_ready)
        else begin
            fail_count++;
            $error("o_ready high after i_valid was low");
        end

    a_result_held: assert property (@(posedge clock) disable iff (i_rst)
        (i_valid && i_ready) ##1 (i_valid && i_ready)
        |-> $stable(i_result_hi) && $stable(i_result_lo))
        else begin
            fail_count++;
            $error("Result changed while o_ready was held");
        end

endmodule

bind malu_top malu_properties u_malu_properties (
    .clock       (clock),
    .i_rst       (i_rst),
    .i_valid     (i_valid),
    .i_ready     (o_ready),
    .i_result_hi (o_result_hi),
    .i_result_lo (o_result_lo)
);

//--- sim/malu_tb.sv
`timescale 1ns/10ps

module malu_tb;

    import malu_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 3;
    localparam int READY_CAP    = 40;                  // Cycles allowed per operation
    localparam int NUM_OPS      = 80;
    localparam int OP_CYCLES    = 45;                  // Watchdog budget per operation
    localparam int ABORT_AT     = 10;                  // Cycles into the op before the abort
    localparam int HOLD_LOW     = 25;                  // Outlasts the aborted op but not a restart

    logic            clock;
    logic            i_rst;
    logic            i_valid;
    logic            i_flush;
    malu_op_t        i_op;
    logic [XLEN-1:0] i_rs1;
    logic [XLEN-1:0] i_rs2;
    logic            i_lhs_sign;
    logic            i_rhs_sign;
    logic            i_div_unsigned;
    logic            o_ready;
    logic [XLEN-1:0] o_result_hi;
    logic [XLEN-1:0] o_result_lo;
    logic [XLEN-1:0] rand_state;

    malu_top u_malu_top (
        .clock          (clock),
        .i_rst          (i_rst),
        .i_valid        (i_valid),
        .i_flush        (i_flush),
        .i_op           (i_op),
        .i_rs1          (i_rs1),
        .i_rs2          (i_rs2),
        .i_lhs_sign     (i_lhs_sign),
        .i_rhs_sign     (i_rhs_sign),
        .i_div_unsigned (i_div_unsigned),
        .o_ready        (o_ready),
        .o_result_hi    (o_result_hi),
        .o_result_lo    (o_result_lo)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    initial begin
        #((NUM_OPS * OP_CYCLES + RESET_CYCLES) * CLK_PERIOD);
        stop_run("Watchdog expired before all tests finished");
    end

    always @(posedge clock) begin
        if (u_malu_top.u_malu_properties.fail_count != 0) begin
            stop_run("A handshake assertion on the DUT failed");
        end
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [ACC_W-1:0] got,
                               input logic [ACC_W-1:0] want);
        if (got !== want) begin
            stop_run($sformatf("ERR %0t %s expected %0h got %0h", $time, name, want, got));
        end
    endtask

    function automatic logic [XLEN-1:0] next_rand();
        logic [XLEN-1:0] x;
        x = rand_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rand_state = x;
        return x;
    endfunction

    // Full product of the operands, each widened by its own signedness
    function automatic logic [ACC_W-1:0] mul_expect(input logic [XLEN-1:0] a, b,
                                                    input logic ls, rs);
        logic [ACC_W-1:0] wa;
        logic [ACC_W-1:0] wb;
        wa = ls ? {{XLEN{a[XLEN-1]}}, a} : {{XLEN{1'b0}}, a};
        wb = rs ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
        return wa * wb;
    endfunction

    function automatic logic [XLEN-1:0] div_expect(input logic want_rem, is_unsigned,
                                                   input logic [XLEN-1:0] a, b);
        int sa;
        int sb;
        logic [XLEN-1:0] r;
        sa = a;
        sb = b;
        if (b == 32'h0) begin
            r = want_rem ? a : 32'hffff_ffff;          // Divide by zero
        end else if (is_unsigned) begin
            r = want_rem ? a % b : a / b;
        end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            r = want_rem ? 32'h0 : 32'h8000_0000;      // Signed overflow
        end else begin
            r = want_rem ? sa % sb : sa / sb;          // Truncates toward zero
        end
        return r;
    endfunction

    task automatic drive_op(input malu_op_t op, input logic [XLEN-1:0] a, b,
                            input logic ls, rs, du);
        i_valid        <= 1'b1;
        i_op           <= op;
        i_rs1          <= a;
        i_rs2          <= b;
        i_lhs_sign     <= ls;
        i_rhs_sign     <= rs;
        i_div_unsigned <= du;
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (o_ready !== 1'b1 && cycles < READY_CAP) begin
            cycles++;
            @(negedge clock);
        end
        if (o_ready !== 1'b1) begin
            stop_run("o_ready did not rise within the cycle limit");
        end
    endtask

    task automatic run_op(input malu_op_t op, input logic [XLEN-1:0] a, b,
                          input logic ls, rs, du, input logic [ACC_W-1:0] want);
        @(posedge clock);
        drive_op(op, a, b, ls, rs, du);
        wait_ready();
        check_value("o_result_hi", o_result_hi, want[ACC_W-1:XLEN]);
        check_value("o_result_lo", o_result_lo, want[XLEN-1:0]);
        @(posedge clock);
        i_valid <= 1'b0;                               // One idle cycle before the next op
    endtask

    task automatic exec_mul(input logic [XLEN-1:0] a, b, input logic ls, rs);
        run_op(OP_MUL, a, b, ls, rs, 1'b0, mul_expect(a, b, ls, rs));
    endtask

    task automatic exec_div(input malu_op_t op, input logic [XLEN-1:0] a, b, input logic du);
        run_op(op, a, b, 1'b0, 1'b0, du, {{XLEN{1'b0}}, div_expect(op == OP_REM, du, a, b)});
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------

    task automatic mul_unsigned_cases();
        repeat (6) begin
            exec_mul(next_rand(), next_rand(), 1'b0, 1'b0);
        end
    endtask

    task automatic mul_signed_cases();
        logic [XLEN-1:0] corner [4];
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        int i;
        int j;
        corner[0] = 32'h8000_0000;
        corner[1] = 32'hffff_ffff;
        corner[2] = 32'h0;
        corner[3] = next_rand();
        for (i = 0; i < 4; i++) begin
            for (j = 0; j < 4; j++) begin
                exec_mul(corner[i], corner[j], 1'b1, 1'b1);
                exec_mul(corner[i], corner[j], 1'b1, 1'b0); // MULHSU form
            end
        end
        repeat (4) begin
            a = next_rand();
            b = next_rand();
            exec_mul(a, b, 1'b1, 1'b1);
            exec_mul(a, b, 1'b1, 1'b0);
        end
    endtask

    task automatic divrem_cases();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        int i;
        for (i = 0; i < 6; i++) begin
            a = next_rand() >> i;
            b = next_rand() >> (4 * i);                // Spread of divisor sizes
            if (b == 32'h0) begin
                b = 32'd7;
            end
            if (i % 2 == 1) begin
                b = -b;                                // Negative when read signed
            end
            exec_div(OP_DIV, a, b, 1'b0);
            exec_div(OP_REM, a, b, 1'b0);
            exec_div(OP_DIV, a, b, 1'b1);
            exec_div(OP_REM, a, b, 1'b1);
        end
    endtask

    task automatic div_corner_cases();
        logic [XLEN-1:0] a;
        a = next_rand() | 32'h8000_0000;
        exec_div(OP_DIV, a, 32'h0, 1'b0);
        exec_div(OP_REM, a, 32'h0, 1'b0);
        exec_div(OP_DIV, a >> 1, 32'h0, 1'b1);
        exec_div(OP_REM, a >> 1, 32'h0, 1'b1);
        exec_div(OP_DIV, 32'h8000_0000, 32'hffff_ffff, 1'b0);
        exec_div(OP_REM, 32'h8000_0000, 32'hffff_ffff, 1'b0);
    endtask

    // Abort partway with a flush pulse or by dropping i_valid
    task automatic abort_cases(input logic use_flush);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        a = next_rand();
        b = next_rand();
        @(posedge clock);
        if (use_flush) begin
            drive_op(OP_DIV, a, b, 1'b0, 1'b0, 1'b0);
        end else begin
            drive_op(OP_MUL, a, b, 1'b1, 1'b1, 1'b0);
        end
        repeat (ABORT_AT) @(posedge clock);
        if (use_flush) begin
            i_flush <= 1'b1;
        end else begin
            i_valid <= 1'b0;
        end
        @(posedge clock);
        i_flush <= 1'b0;
        i_valid <= 1'b1;                               // Same op starts again from scratch
        repeat (HOLD_LOW) begin
            @(negedge clock);
            check_value("o_ready", o_ready, '0);
        end
        @(posedge clock);
        i_valid <= 1'b0;
        if (use_flush) begin
            exec_mul(~a, b ^ 32'h0f0f_0f0f, 1'b1, 1'b0);
        end else begin
            exec_div(OP_REM, ~a, b | 32'd1, 1'b0);
        end
    endtask

    initial begin
        clock          = 1'b0;
        i_rst          = 1'b1;
        i_valid        = 1'b0;
        i_flush        = 1'b0;
        i_op           = OP_NONE;
        i_rs1          = '0;
        i_rs2          = '0;
        i_lhs_sign     = 1'b0;
        i_rhs_sign     = 1'b0;
        i_div_unsigned = 1'b0;
        rand_state     = 32'h8a41;
        repeat (RESET_CYCLES) @(posedge clock);
        i_rst <= 1'b0;
        mul_unsigned_cases();
        mul_signed_cases();
        divrem_cases();
        div_corner_cases();
        abort_cases(1'b1);
        abort_cases(1'b0);
        if (u_malu_top.u_malu_properties.fail_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            stop_run("A handshake assertion on the DUT failed");
        end
    end

endmodule
